/* source/dds_pkg.sv */
// shared widths, register kinds and structs for the multi-channel DDS
// phase and sample widths are fixed here and are not module parameters
package dds_pkg;

  // phase word width, one full turn is 2^PHASE_BITS
  localparam int PHASE_BITS = 32;
  // signed output sample width
  localparam int SAMPLE_WIDTH = 16;
  // dither LFSR width, one word per lane
  localparam int LFSR_BITS = 16;

  typedef logic [PHASE_BITS-1:0] phase_t;
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  // register kinds on the config write port
  typedef enum logic [1:0] {
    REG_PHASE_INC    = 2'd0,
    REG_PHASE_OFFSET = 2'd1,
    // data bit 0 is the dither enable
    REG_CONTROL      = 2'd2,
    // global command, channel and data ignored
    REG_SYNC         = 2'd3
  } reg_kind_e;

  // one write request, 42 bits
  typedef struct packed {
    reg_kind_e  kind;
    logic [7:0] channel;
    phase_t     data;
  } cfg_write_t;

  // live settings of one channel, 65 bits
  typedef struct packed {
    phase_t phase_inc;
    phase_t phase_offset;
    logic   dither_en;
  } channel_cfg_t;

endpackage

/* source/dds_config_regs.sv */
// config register block with a four-phase req/ack write port
// cfg_write must stay stable while cfg_req is high; no readback
`timescale 1ns/100ps

module dds_config_regs import dds_pkg::*; #(
  parameter int CHANNELS = 2
) (
  input  logic                         dac_clk,
  input  logic                         dac_reset,
  input  logic                         cfg_req,
  input  cfg_write_t                   cfg_write,
  output logic                         cfg_ack,
  output channel_cfg_t [CHANNELS-1:0]  channel_cfg,
  output logic                         sync
);

  // a new request is taken only while ack is low
  logic wr_accept;

  assign wr_accept = cfg_req && !cfg_ack;

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      cfg_ack     <= 1'b0;
      sync        <= 1'b0;
      channel_cfg <= '0;
    end else begin
      // sync is a single cycle pulse
      sync <= 1'b0;
      if (wr_accept) begin
        // apply and acknowledge on the same edge
        cfg_ack <= 1'b1;
        // sync is global, so the channel field does not matter
        if (cfg_write.kind == REG_SYNC) begin
          sync <= 1'b1;
        end
        // channels at or above CHANNELS match nothing here
        // and the write is only acknowledged
        for (int c = 0; c < CHANNELS; c++) begin
          if (cfg_write.channel == 8'(c)) begin
            case (cfg_write.kind)
              REG_PHASE_INC: begin
                channel_cfg[c].phase_inc <= cfg_write.data;
              end
              REG_PHASE_OFFSET: begin
                channel_cfg[c].phase_offset <= cfg_write.data;
              end
              REG_CONTROL: begin
                channel_cfg[c].dither_en <= cfg_write.data[0];
              end
              default: begin
                // REG_SYNC has no per-channel field
                channel_cfg[c] <= channel_cfg[c];
              end
            endcase
          end
        end
      end else if (!cfg_req) begin
        // master has released req, close the handshake
        cfg_ack <= 1'b0;
      end
    end
  end

  // ack only rises in answer to a request
  ack_needs_req: assert property (
    @(posedge dac_clk) disable iff (dac_reset)
    $rose(cfg_ack) |-> $past(cfg_req)
  ) else $error("cfg_ack rose without cfg_req");

  // the handshake keeps sync from repeating on back to back edges
  sync_single: assert property (
    @(posedge dac_clk) disable iff (dac_reset)
    sync |=> !sync
  ) else $error("sync high for two cycles");

endmodule

/* source/dither_lfsr.sv */
// 16-bit maximal Fibonacci LFSR, unrolled to PARALLEL_SAMPLES steps per clock
// SEED must be nonzero; lane i sees the i-th consecutive state
`timescale 1ns/100ps

module dither_lfsr import dds_pkg::*; #(
  parameter int               PARALLEL_SAMPLES = 4,
  parameter logic [LFSR_BITS-1:0] SEED         = 16'hace1
) (
  input  logic                                        dac_clk,
  input  logic                                        dac_reset,
  output logic [PARALLEL_SAMPLES-1:0][LFSR_BITS-1:0]  lfsr_words
);

  logic [LFSR_BITS-1:0] state;
  // chain of states, entry 0 is the register itself
  logic [PARALLEL_SAMPLES:0][LFSR_BITS-1:0] chain;

  // one step with taps 16,15,13,4, shifting toward the msb
  function automatic logic [LFSR_BITS-1:0] lfsr_step(input logic [LFSR_BITS-1:0] s);
    logic feedback;
    feedback = s[15] ^ s[14] ^ s[12] ^ s[3];
    return {s[LFSR_BITS-2:0], feedback};
  endfunction

  always_comb begin
    chain[0] = state;
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      chain[i+1] = lfsr_step(chain[i]);
    end
  end

  // every lane gets its own state of this clock's run
  always_comb begin
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      lfsr_words[i] = chain[i];
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      state <= SEED;
    end else begin
      // jump ahead by the full lane count
      state <= chain[PARALLEL_SAMPLES];
    end
  end

  // all-zero is the lock-up state of this feedback
  state_nonzero: assert property (
    @(posedge dac_clk) disable iff (dac_reset)
    state != '0
  ) else $error("dither LFSR reached the all-zero state");

endmodule

/* source/phase_accumulator.sv */
// per-channel phase accumulator producing one phase per lane each clock
// lane phases follow the increment only once it has been stable one cycle
`timescale 1ns/100ps

module phase_accumulator import dds_pkg::*; #(
  parameter int PARALLEL_SAMPLES = 4
) (
  input  logic                           dac_clk,
  input  logic                           dac_reset,
  input  channel_cfg_t                   channel_cfg,
  input  logic                           sync,
  output phase_t [PARALLEL_SAMPLES-1:0]  lane_phase,
  output logic                           first
);

  // inc_mult[i] holds (i+1) times the increment
  phase_t [PARALLEL_SAMPLES-1:0] inc_mult;
  // phase of lane 0 before the offset is added
  phase_t cycle_phase;
  // set while cycle_phase holds the value zeroed by sync
  logic zero_flag;
  // extra phase of each lane over lane 0
  phase_t [PARALLEL_SAMPLES-1:0] lane_step;

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      inc_mult    <= '0;
      cycle_phase <= '0;
      zero_flag   <= 1'b0;
      first       <= 1'b0;
    end else begin
      // multiples follow the settings one cycle late
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        inc_mult[i] <= phase_t'(channel_cfg.phase_inc * phase_t'(i + 1));
      end
      // a whole block moves on by PARALLEL_SAMPLES increments
      if (sync) begin
        cycle_phase <= '0;
      end else begin
        cycle_phase <= cycle_phase + inc_mult[PARALLEL_SAMPLES-1];
      end
      zero_flag <= sync;
      // the block built from the zeroed cycle phase is the marked one
      first <= zero_flag;
    end
  end

  always_comb begin
    lane_step[0] = '0;
    for (int i = 1; i < PARALLEL_SAMPLES; i++) begin
      lane_step[i] = inc_mult[i-1];
    end
  end

  // lane phase = offset + cycle phase + i * increment, wrapping mod 2^32
  always_ff @(posedge dac_clk) begin
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      lane_phase[i] <= channel_cfg.phase_offset + cycle_phase + lane_step[i];
    end
  end

endmodule

/* source/phase_to_amplitude.sv */
// dither add, phase quantization and full-turn cosine lookup, 3 cycles
// QUANT_BITS must be 1 to 31; the table has 2^(32-QUANT_BITS) entries
`timescale 1ns/100ps

module phase_to_amplitude import dds_pkg::*; #(
  parameter int QUANT_BITS       = 20,
  parameter int PARALLEL_SAMPLES = 4
) (
  input  logic                                        dac_clk,
  input  logic                                        dac_reset,
  input  phase_t [PARALLEL_SAMPLES-1:0]               lane_phase,
  input  logic                                        first,
  input  logic                                        dither_en,
  input  logic [PARALLEL_SAMPLES-1:0][LFSR_BITS-1:0]  lfsr_words,
  output sample_t [PARALLEL_SAMPLES-1:0]              samples,
  output logic                                        first_out
);

  localparam int  ADDR_BITS = PHASE_BITS - QUANT_BITS;
  localparam int  DEPTH     = 2 ** ADDR_BITS;
  localparam real PI        = 3.141592653589793;
  // peak kept half an lsb inside full scale
  localparam real AMPLITUDE = 2.0 ** (SAMPLE_WIDTH - 1) - 0.5;

  sample_t lut [DEPTH];
  phase_t [PARALLEL_SAMPLES-1:0] dither_word;
  phase_t [PARALLEL_SAMPLES-1:0] dithered;
  logic [PARALLEL_SAMPLES-1:0][ADDR_BITS-1:0] addr;
  // first marker delayed with the three data stages
  logic [2:0] first_pipe;

  // whole turn in the table, so no quadrant folding is needed
  initial begin
    for (int k = 0; k < DEPTH; k++) begin
      lut[k] = sample_t'(int'($floor($cos(2.0 * PI * real'(k) / real'(DEPTH))
                                     * AMPLITUDE - 0.5)));
    end
  end

  // line up the LFSR word just below the table address bits
  if (QUANT_BITS > LFSR_BITS) begin : g_dither_shift
    always_comb begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        dither_word[i] = phase_t'(lfsr_words[i]) << (QUANT_BITS - LFSR_BITS);
      end
    end
  end else begin : g_dither_trunc
    // narrow quantization keeps only the low LFSR bits
    always_comb begin
      for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
        dither_word[i] = phase_t'(lfsr_words[i][QUANT_BITS-1:0]);
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
      // stage 1: dither
      dithered[i] <= lane_phase[i] + (dither_en ? dither_word[i] : '0);
      // stage 2: drop the low QUANT_BITS
      addr[i]     <= dithered[i][PHASE_BITS-1:QUANT_BITS];
      // stage 3: table read
      samples[i]  <= lut[addr[i]];
    end
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      first_pipe <= '0;
    end else begin
      first_pipe <= {first_pipe[1:0], first};
    end
  end

  assign first_out = first_pipe[2];

endmodule

/* source/dds_top.sv */
// multi-channel DDS top in one clock domain with no back-pressure on samples
// dac_first comes from channel 0 and sync reaches all channels on the same edge
`timescale 1ns/100ps

module dds_top import dds_pkg::*; #(
  parameter int QUANT_BITS       = 20,
  parameter int PARALLEL_SAMPLES = 4,
  parameter int CHANNELS         = 2
) (
  input  logic                                          dac_clk,
  input  logic                                          dac_reset,
  input  logic                                          cfg_req,
  input  cfg_write_t                                    cfg_write,
  output logic                                          cfg_ack,
  output sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0]  dac_samples,
  output logic                                          dac_valid,
  output logic                                          dac_first
);

  channel_cfg_t [CHANNELS-1:0] channel_cfg;
  logic sync;
  // per-channel first markers at the output
  logic [CHANNELS-1:0] first_out;
  // startup delay covering accumulator and lookup latency
  logic [4:0] valid_pipe;

  dds_config_regs #(
    .CHANNELS(CHANNELS)
  ) dds_config_regs_inst (
    .dac_clk,
    .dac_reset,
    .cfg_req,
    .cfg_write,
    .cfg_ack,
    .channel_cfg,
    .sync
  );

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel
    logic [PARALLEL_SAMPLES-1:0][LFSR_BITS-1:0] lfsr_words;
    phase_t [PARALLEL_SAMPLES-1:0] lane_phase;
    logic first;

    // seed differs per channel while the low nibble stays nonzero
    dither_lfsr #(
      .PARALLEL_SAMPLES(PARALLEL_SAMPLES),
      .SEED(16'hace1 ^ 16'(ch << 4))
    ) dither_lfsr_inst (
      .dac_clk,
      .dac_reset,
      .lfsr_words
    );

    phase_accumulator #(
      .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
    ) phase_accumulator_inst (
      .dac_clk,
      .dac_reset,
      .channel_cfg(channel_cfg[ch]),
      .sync,
      .lane_phase,
      .first
    );

    phase_to_amplitude #(
      .QUANT_BITS(QUANT_BITS),
      .PARALLEL_SAMPLES(PARALLEL_SAMPLES)
    ) phase_to_amplitude_inst (
      .dac_clk,
      .dac_reset,
      .lane_phase,
      .first,
      .dither_en(channel_cfg[ch].dither_en),
      .lfsr_words,
      .samples(dac_samples[ch]),
      .first_out(first_out[ch])
    );
  end

  // valid rises 5 cycles after reset and then stays high
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[3:0], 1'b1};
    end
  end

  assign dac_valid = valid_pipe[4];
  assign dac_first = first_out[0];

endmodule

/* testbench/dds_tb.sv */
// directed testbench for dds_top at default parameters
// expected samples come from the phase rule and a rebuilt table; the LFSR is not modelled
`timescale 1ns/100ps

module dds_tb import dds_pkg::*; ();

  localparam int  QUANT_BITS       = 20;
  localparam int  PARALLEL_SAMPLES = 4;
  localparam int  CHANNELS         = 2;
  localparam int  DEPTH            = 2 ** (PHASE_BITS - QUANT_BITS);
  localparam int  CYCLE_LIMIT      = 6000;
  localparam int  ACK_TIMEOUT      = 20;
  localparam int  FIRST_TIMEOUT    = 40;
  localparam real PI               = 3.141592653589793;

  logic dac_clk;
  logic dac_reset;
  logic cfg_req;
  cfg_write_t cfg_write;
  logic cfg_ack;
  sample_t [CHANNELS-1:0][PARALLEL_SAMPLES-1:0] dac_samples;
  logic dac_valid;
  logic dac_first;

  // reference cosine table and mirror of the programmed settings
  sample_t ref_table [DEPTH];
  phase_t exp_inc [CHANNELS];
  phase_t exp_off [CHANNELS];
  logic exp_dither [CHANNELS];
  int seed;
  int error_count;
  int check_count;
  int cycle_count;
  logic valid_seen;
  // dither hits on the lower and upper neighbor entries
  int lower_hits;
  int upper_hits;

  dds_top dds_top_inst (
    .dac_clk,
    .dac_reset,
    .cfg_req,
    .cfg_write,
    .cfg_ack,
    .dac_samples,
    .dac_valid,
    .dac_first
  );

  always #50 dac_clk = ~dac_clk;

  // hard stop well past the longest test sequence
  always @(posedge dac_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  // once valid is up it must never drop again
  always @(negedge dac_clk) begin
    if (valid_seen) begin
      compare_flag("dac_valid held", dac_valid, 1'b1);
    end
  end

  task automatic compare_sample(input sample_t got, input sample_t expected,
                                input int ch, input int lane, input int blk);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("mismatch at %0t: channel %0d lane %0d block %0d got %0d expected %0d",
               $time, ch, lane, blk, got, expected);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, expected);
    end
  endtask

  task automatic log_failure(input string text);
    error_count++;
    $display("error at %0t: %s", $time, text);
  endtask

  task automatic print_test_result(input string name, input int start_errors);
    $display("test %s finished with %0d errors", name, error_count - start_errors);
  endtask

  // returns k table steps for a random k from 1 to 2048
  function automatic phase_t random_step();
    int k;
    k = ($random(seed) & 32'h7ff) + 1;
    return phase_t'(k) << QUANT_BITS;
  endfunction

  // full four-phase write that updates the mirror once acked
  task automatic write_reg(input reg_kind_e reg_kind, input int ch, input phase_t value);
    int waited;
    waited = 0;
    @(posedge dac_clk);
    cfg_write <= '{kind: reg_kind, channel: 8'(ch), data: value};
    cfg_req <= 1'b1;
    @(negedge dac_clk);
    while (!cfg_ack && waited < ACK_TIMEOUT) begin
      @(negedge dac_clk);
      waited++;
    end
    if (!cfg_ack) begin
      log_failure($sformatf("cfg_ack did not come within %0d cycles", ACK_TIMEOUT));
    end else if (ch < CHANNELS) begin
      case (reg_kind)
        REG_PHASE_INC:    exp_inc[ch] = value;
        REG_PHASE_OFFSET: exp_off[ch] = value;
        REG_CONTROL:      exp_dither[ch] = value[0];
        default:          ;
      endcase
    end
    @(posedge dac_clk);
    cfg_req <= 1'b0;
    // ack drops on the edge that sees req low
    @(posedge dac_clk);
    @(negedge dac_clk);
    compare_flag("cfg_ack release", cfg_ack, 1'b0);
  endtask

  // waits for the marked block and checks it and the blocks that follow
  task automatic check_tone(input int blocks);
    int waited;
    int addr;
    phase_t phase;
    sample_t lower;
    sample_t upper;
    sample_t got;
    waited = 0;
    while (!dac_first && waited < FIRST_TIMEOUT) begin
      @(negedge dac_clk);
      waited++;
    end
    if (!dac_first) begin
      log_failure("dac_first never marked a block after sync");
      return;
    end
    for (int n = 0; n < blocks; n++) begin
      compare_flag("dac_first", dac_first, n == 0);
      compare_flag("dac_valid", dac_valid, 1'b1);
      for (int ch = 0; ch < CHANNELS; ch++) begin
        for (int i = 0; i < PARALLEL_SAMPLES; i++) begin
          phase = exp_off[ch] + phase_t'(n * PARALLEL_SAMPLES + i) * exp_inc[ch];
          addr = int'(phase >> QUANT_BITS);
          lower = ref_table[addr];
          upper = ref_table[(addr + 1) % DEPTH];
          got = dac_samples[ch][i];
          // dither may carry the address one entry up
          if (exp_dither[ch] && got == upper && lower != upper) begin
            upper_hits++;
            compare_sample(got, upper, ch, i, n);
          end else begin
            if (exp_dither[ch] && got == lower && lower != upper) begin
              lower_hits++;
            end
            compare_sample(got, lower, ch, i, n);
          end
        end
      end
      @(negedge dac_clk);
    end
  endtask

  task automatic reset_and_valid();
    int start_errors;
    start_errors = error_count;
    repeat (3) @(posedge dac_clk);
    dac_reset <= 1'b0;
    // valid stays low for 5 cycles after release
    for (int c = 0; c < 5; c++) begin
      @(negedge dac_clk);
      compare_flag("cfg_ack after reset", cfg_ack, 1'b0);
      compare_flag("dac_first after reset", dac_first, 1'b0);
      compare_flag("dac_valid startup", dac_valid, 1'b0);
    end
    @(negedge dac_clk);
    compare_flag("dac_valid rise", dac_valid, 1'b1);
    valid_seen = 1'b1;
    print_test_result("reset and valid", start_errors);
  endtask

  task automatic handshake_writes();
    int start_errors;
    start_errors = error_count;
    write_reg(REG_PHASE_INC, 0, phase_t'(3) << QUANT_BITS);
    write_reg(REG_PHASE_INC, 1, phase_t'(7) << QUANT_BITS);
    // out of range channel is acked and ignored
    write_reg(REG_PHASE_INC, 5, 32'h1234_5678);
    write_reg(REG_PHASE_OFFSET, 5, 32'h4000_0000);
    write_reg(REG_SYNC, 0, '0);
    check_tone(8);
    print_test_result("handshake", start_errors);
  endtask

  task automatic exact_tones();
    int start_errors;
    phase_t step0;
    phase_t step1;
    start_errors = error_count;
    step0 = random_step();
    do begin
      step1 = random_step();
    end while (step1 == step0);
    write_reg(REG_PHASE_INC, 0, step0);
    write_reg(REG_PHASE_INC, 1, step1);
    write_reg(REG_SYNC, 0, '0);
    check_tone(64);
    print_test_result("exact tones", start_errors);
  endtask

  task automatic offset_tone();
    int start_errors;
    start_errors = error_count;
    write_reg(REG_PHASE_INC, 1, exp_inc[0]);
    // quarter turn puts channel 1 DEPTH/4 entries ahead
    write_reg(REG_PHASE_OFFSET, 1, 32'h4000_0000);
    write_reg(REG_SYNC, 0, '0);
    check_tone(64);
    print_test_result("phase offset", start_errors);
  endtask

  task automatic dither_bound();
    int start_errors;
    start_errors = error_count;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      write_reg(REG_CONTROL, ch, 32'd1);
      // half a table step
      write_reg(REG_PHASE_OFFSET, ch, phase_t'(1) << (QUANT_BITS - 1));
    end
    write_reg(REG_SYNC, 0, '0);
    lower_hits = 0;
    upper_hits = 0;
    check_tone(64);
    if (lower_hits == 0 || upper_hits == 0) begin
      log_failure("dithered samples did not reach both neighboring table entries");
    end
    print_test_result("dither bound", start_errors);
  endtask

  task automatic retune_tone();
    int start_errors;
    phase_t step;
    start_errors = error_count;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      write_reg(REG_CONTROL, ch, 32'd0);
    end
    do begin
      step = random_step();
    end while (step == exp_inc[0]);
    // new increment goes in well before the sync
    write_reg(REG_PHASE_INC, 0, step);
    repeat (10) @(posedge dac_clk);
    write_reg(REG_SYNC, 0, '0);
    check_tone(64);
    print_test_result("retune", start_errors);
  endtask

  initial begin
    dac_clk = 1'b0;
    dac_reset = 1'b1;
    cfg_req = 1'b0;
    cfg_write = '0;
    seed = 32'h849418f6;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    valid_seen = 1'b0;
    lower_hits = 0;
    upper_hits = 0;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      exp_inc[ch] = '0;
      exp_off[ch] = '0;
      exp_dither[ch] = 1'b0;
    end
    // entry k = floor(cos(2 pi k / depth) * (2^15 - 0.5) - 0.5)
    for (int k = 0; k < DEPTH; k++) begin
      ref_table[k] = sample_t'(int'($floor($cos(2.0 * PI * real'(k) / real'(DEPTH))
                                           * (32768.0 - 0.5) - 0.5)));
    end
    reset_and_valid();
    handshake_writes();
    exact_tones();
    offset_tone();
    dither_bound();
    retune_tone();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* compile.f */
source/dds_pkg.sv
source/dds_config_regs.sv
source/dither_lfsr.sv
source/phase_accumulator.sv
source/phase_to_amplitude.sv
source/dds_top.sv
testbench/dds_tb.sv

/* Makefile */
# Verilator build and run of the DDS testbench
SIM := obj_dir/dds_sim

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module dds_tb \
		-f compile.f -o dds_sim
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
